//--- xlat.f
+incdir+logic
logic/xlat_pkg.sv
logic/xlat_front.sv
logic/tlb_array.sv
logic/xlat_check.sv
logic/xlat_top.sv
dv/xlat_chk.sv
dv/xlat_tb.sv

//--- Bender.yml
package:
  name: xlat

export_include_dirs:
  - logic

sources:
  - logic/xlat_pkg.sv
  - logic/xlat_front.sv
  - logic/tlb_array.sv
  - logic/xlat_check.sv
  - logic/xlat_top.sv
  - target: test
    files:
      - dv/xlat_chk.sv
      - dv/xlat_tb.sv

//--- dv/xlat_tb.sv
`default_nettype none
`include "xlat_settings.svh"

module xlat_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic                       clk;
    logic                       reset;
    logic                       req_valid;
    xlat_pkg::xlat_req_t        req;
    xlat_pkg::xlat_cfg_t        cfg;
    logic                       tlb_we;
    logic [`XLAT_TLB_IDX_W-1:0] tlb_windex;
    xlat_pkg::tlb_entry_t       tlb_wentry;
    logic                       rsp_valid;
    xlat_pkg::xlat_rsp_t        rsp;

    // model copies of what the DUT was given
    xlat_pkg::xlat_cfg_t        cfg_m;
    xlat_pkg::tlb_entry_t       tlb_m [`XLAT_TLB_ENTRIES];
    xlat_pkg::xlat_rsp_t        exp_q [$];
    xlat_pkg::xlat_cfg_t        c;
    xlat_pkg::tlb_entry_t       ent;
    logic [31:0]                lfsr;
    string                      test_name;
    int                         test_errs;
    int                         total_errs;
    int                         tests_run;
    int                         tests_failed;
    int                         checked;
    int                         lat;

    xlat_top i_dut (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req        (req),
        .cfg        (cfg),
        .tlb_we     (tlb_we),
        .tlb_windex (tlb_windex),
        .tlb_wentry (tlb_wentry),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp)
    );

    always #50 clk = ~clk;

    // galois lfsr, one step per bit
    function automatic logic [31:0] rnd(input int nbits);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++)
        begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic xlat_pkg::xlat_req_t rand_req(input logic [31:0] va);
        xlat_pkg::xlat_req_t r;
        logic [1:0]          a;
        a = rnd(2);
        r.vaddr  = va;
        r.access = (a == 2'd3) ? xlat_pkg::acc_load : xlat_pkg::access_e'(a);
        r.plv    = rnd(2);
        return r;
    endfunction

    // small vppn pool so entries overlap
    function automatic xlat_pkg::tlb_entry_t rand_entry();
        xlat_pkg::tlb_entry_t t;
        t.e       = (rnd(2) != 0);
        t.vppn    = {16'habcd, 3'd0} | rnd(2);
        t.asid    = rnd(1) ? cfg_m.asid : rnd(10);
        t.g       = (rnd(2) == 0);
        t.page0   = rnd(26);
        t.page0.v = (rnd(2) != 0);
        t.page1   = rnd(26);
        t.page1.v = (rnd(2) != 0);
        return t;
    endfunction

    function automatic logic window_hit(input xlat_pkg::dmw_t w, input xlat_pkg::xlat_req_t r);
        if (r.vaddr[31:29] != w.vseg)
            return 1'b0;
        case (r.plv)
            2'd0:    return w.plv0;
            2'd3:    return w.plv3;
            default: return 1'b0;
        endcase
    endfunction

    function automatic xlat_pkg::xlat_rsp_t ref_xlat(input xlat_pkg::xlat_req_t r,
                                                     input xlat_pkg::xlat_cfg_t cf);
        xlat_pkg::xlat_rsp_t o;
        xlat_pkg::dmw_t      w;
        xlat_pkg::page_t     pg;
        int                  sel;
        o = '0;
        o.fault = xlat_pkg::fault_none;
        if (cf.da)
        begin
            o.paddr = r.vaddr;
            o.mat   = (r.access == xlat_pkg::acc_fetch) ? cf.datf : cf.datm;
            return o;
        end
        if (window_hit(cf.dmw0, r) || window_hit(cf.dmw1, r))
        begin
            w = window_hit(cf.dmw0, r) ? cf.dmw0 : cf.dmw1;
            o.paddr = {w.pseg, r.vaddr[28:0]};
            o.mat   = w.mat;
            return o;
        end
        // scan downward so the lowest hit is kept
        sel = -1;
        for (int i = `XLAT_TLB_ENTRIES - 1; i >= 0; i--)
        begin
            if (tlb_m[i].e && tlb_m[i].vppn == r.vaddr[31:13]
                && (tlb_m[i].g || tlb_m[i].asid == cf.asid))
                sel = i;
        end
        if (sel < 0)
            return '{paddr: '0, mat: 2'd0, fault: xlat_pkg::fault_refill};
        pg = r.vaddr[12] ? tlb_m[sel].page1 : tlb_m[sel].page0;
        if (!pg.v)
        begin
            case (r.access)
                xlat_pkg::acc_fetch: o.fault = xlat_pkg::fault_inv_fetch;
                xlat_pkg::acc_load:  o.fault = xlat_pkg::fault_inv_load;
                default:             o.fault = xlat_pkg::fault_inv_store;
            endcase
        end
        else if (r.plv > pg.plv)
            o.fault = xlat_pkg::fault_priv;
        else if (r.access == xlat_pkg::acc_store && !pg.d)
            o.fault = xlat_pkg::fault_modify;
        else
        begin
            o.paddr = {pg.ppn, r.vaddr[11:0]};
            o.mat   = pg.mat;
        end
        return o;
    endfunction

    function automatic string format_rsp(input xlat_pkg::xlat_rsp_t x);
        return $sformatf("paddr=%h mat=%0d fault=%0d", x.paddr, x.mat, x.fault);
    endfunction

    task automatic send(input xlat_pkg::xlat_req_t r);
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= r;
        exp_q.push_back(ref_xlat(r, cfg_m));
    endtask

    task automatic drain();
        int waited;
        @(posedge clk);
        req_valid <= 1'b0;
        waited = 0;
        while (exp_q.size() != 0 && waited < 20)
        begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0)
        begin
            $display("timeout in %s: %0d responses never arrived", test_name, exp_q.size());
            test_errs++;
            exp_q.delete();
        end
    endtask

    task automatic set_cfg(input xlat_pkg::xlat_cfg_t nc);
        @(posedge clk);
        cfg_m = nc;
        cfg  <= nc;
    endtask

    task automatic write_tlb(input int idx, input xlat_pkg::tlb_entry_t e);
        @(posedge clk);
        tlb_we     <= 1'b1;
        tlb_windex <= idx[`XLAT_TLB_IDX_W-1:0];
        tlb_wentry <= e;
        tlb_m[idx] = e;
        @(posedge clk);
        tlb_we <= 1'b0;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        drain();
        tests_run++;
        total_errs += test_errs;
        if (test_errs == 0)
            $display("test %s: passed", test_name);
        else
        begin
            tests_failed++;
            $display("test %s: %0d mismatches", test_name, test_errs);
        end
    endtask

    // response compare
    always @(posedge clk)
    begin : compare_rsp
        xlat_pkg::xlat_rsp_t e;
        if (!reset && rsp_valid === 1'b1)
        begin
            if (exp_q.size() == 0)
            begin
                $display("%s: response arrived with no request outstanding", test_name);
                test_errs++;
            end
            else
            begin
                e = exp_q.pop_front();
                checked++;
                if (rsp !== e)
                begin
                    $display("error %s: expected %s, actual %s",
                             test_name, format_rsp(e), format_rsp(rsp));
                    test_errs++;
                end
            end
        end
    end

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        req_valid = 1'b0;
        req = '0;
        cfg = '0;
        cfg_m = '0;
        tlb_we = 1'b0;
        tlb_windex = '0;
        tlb_wentry = '0;
        lfsr = 32'd89372;
        test_errs = 0;
        total_errs = 0;
        tests_run = 0;
        tests_failed = 0;
        checked = 0;
        foreach (tlb_m[i])
            tlb_m[i] = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        // quiet after reset, then one request
        begin_test("after_reset");
        repeat (4) @(posedge clk);
        send(rand_req(rnd(32)));
        @(posedge clk);
        req_valid <= 1'b0;
        lat = 0;
        while (rsp_valid !== 1'b1 && lat < 10)
        begin
            @(negedge clk);
            lat++;
        end
        if (rsp_valid !== 1'b1)
        begin
            $display("timeout in %s: no response within 10 cycles", test_name);
            test_errs++;
        end
        else if (lat != 2)
        begin
            $display("error %s: expected latency 2, actual latency %0d", test_name, lat);
            test_errs++;
        end
        end_test();

        begin_test("direct");
        c = '0;
        c.da = 1'b1;
        c.datf = 2'd1;
        c.datm = 2'd2;
        set_cfg(c);
        repeat (24) send(rand_req(rnd(32)));
        end_test();

        // second round drops plv3 from dmw1
        begin_test("windows");
        c = '0;
        c.asid = 10'h055;
        c.dmw0 = '{plv0: 1'b1, plv3: 1'b0, mat: 2'd1, pseg: 3'd1, vseg: 3'd5};
        c.dmw1 = '{plv0: 1'b1, plv3: 1'b1, mat: 2'd2, pseg: 3'd2, vseg: 3'd5};
        for (int round = 0; round < 2; round++)
        begin
            c.dmw1.plv3 = (round == 0);
            set_cfg(c);
            repeat (20) send(rand_req(rnd(1) ? ({3'd5, 29'd0} | rnd(29)) : rnd(32)));
            drain();
        end
        end_test();

        begin_test("tlb_hits");
        c.dmw0 = '0;
        c.dmw1 = '0;
        set_cfg(c);
        for (int i = 0; i < `XLAT_TLB_ENTRIES; i++)
            write_tlb(i, rand_entry());
        repeat (48) send(rand_req({16'habcd, 16'h0} | rnd(16)));
        drain();
        // foreign asid leaves only global entries
        c.asid = 10'h3a1;
        set_cfg(c);
        repeat (32) send(rand_req({16'habcd, 16'h0} | rnd(16)));
        end_test();

        begin_test("faults");
        ent = '0;
        ent.e = 1'b1;
        ent.g = 1'b1;
        ent.vppn = 19'h12340;
        ent.page0 = '{ppn: 20'h0beef, plv: 2'd0, mat: 2'd1, d: 1'b1, v: 1'b0};
        ent.page1 = '{ppn: 20'h0cafe, plv: 2'd1, mat: 2'd3, d: 1'b0, v: 1'b1};
        write_tlb(0, ent);
        send('{{19'h12340, 13'h0123}, xlat_pkg::acc_fetch, 2'd0});
        send('{{19'h12340, 13'h0123}, xlat_pkg::acc_load, 2'd0});
        send('{{19'h12340, 13'h0123}, xlat_pkg::acc_store, 2'd0});
        send('{{19'h12340, 13'h0123}, xlat_pkg::acc_store, 2'd3});
        send('{{19'h12340, 13'h1456}, xlat_pkg::acc_load, 2'd0});
        send('{{19'h12340, 13'h1456}, xlat_pkg::acc_fetch, 2'd1});
        send('{{19'h12340, 13'h1456}, xlat_pkg::acc_store, 2'd1});
        send('{{19'h12340, 13'h1456}, xlat_pkg::acc_store, 2'd3});
        send('{{19'h12340, 13'h1456}, xlat_pkg::acc_load, 2'd2});
        send('{{19'h12341, 13'h0789}, xlat_pkg::acc_load, 2'd0});
        end_test();

        begin_test("back_to_back");
        for (int round = 0; round < 4; round++)
        begin
            c[31:0] = rnd(32);
            c[35:32] = rnd(4);
            c.da = (round == 0);
            c.asid = rnd(1) ? 10'h055 : rnd(10);
            set_cfg(c);
            repeat (32) send(rand_req(rnd(1) ? ({16'habcd, 16'h0} | rnd(16)) : rnd(32)));
            drain();
        end
        end_test();

        $display("%0d tests, %0d failed, %0d checked, %0d mismatches, %0d assertion failures",
                 tests_run, tests_failed, checked, total_errs, i_dut.i_chk.fail_cnt);
        if (total_errs == 0 && tests_failed == 0 && i_dut.i_chk.fail_cnt == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/xlat_chk.sv
`default_nettype none

module xlat_chk (
    input wire                      clk,
    input wire                      reset,
    input wire                      req_valid,
    input wire                      rsp_valid,
    input wire xlat_pkg::xlat_cfg_t cfg,
    input wire xlat_pkg::xlat_rsp_t rsp
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_cnt = 0;

    // strobe is cleared by reset
    assert property (@(posedge clk) reset |=> !rsp_valid)
    else
    begin
        fail_cnt++;
        $error("rsp_valid high in the cycle after reset");
    end

    // fixed two-edge latency, one response per request
    assert property (@(posedge clk) disable iff (reset)
        rsp_valid == $past(req_valid, 2))
    else
    begin
        fail_cnt++;
        $error("rsp_valid does not follow req_valid by two edges");
    end

    assert property (@(posedge clk) disable iff (reset)
        (rsp_valid && cfg.da) |-> (rsp.fault == xlat_pkg::fault_none))
    else
    begin
        fail_cnt++;
        $error("fault reported in direct address mode");
    end

endmodule

bind xlat_top xlat_chk i_chk (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .rsp_valid (rsp_valid),
    .cfg       (cfg),
    .rsp       (rsp)
);

`default_nettype wire

//--- logic/xlat_top.sv
`default_nettype none
`include "xlat_settings.svh"

module xlat_top (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              req_valid,
    input  wire xlat_pkg::xlat_req_t         req,
    input  wire xlat_pkg::xlat_cfg_t         cfg,
    input  wire                              tlb_we,
    input  wire [`XLAT_TLB_IDX_W-1:0]        tlb_windex,
    input  wire xlat_pkg::tlb_entry_t        tlb_wentry,
    output logic                             rsp_valid,
    output xlat_pkg::xlat_rsp_t              rsp
);

    logic                  front_valid;
    xlat_pkg::front_t      front;
    xlat_pkg::tlb_match_t  match;

    xlat_front u_front (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req         (req),
        .cfg         (cfg),
        .front_valid (front_valid),
        .front       (front)
    );

    // searched with the request held in stage 1
    tlb_array u_tlb (
        .clk    (clk),
        .reset  (reset),
        .we     (tlb_we),
        .windex (tlb_windex),
        .wentry (tlb_wentry),
        .vaddr  (front.req.vaddr),
        .asid   (cfg.asid),
        .match  (match)
    );

    xlat_check u_check (
        .clk         (clk),
        .reset       (reset),
        .front_valid (front_valid),
        .front       (front),
        .match       (match),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp)
    );

endmodule

`default_nettype wire

//--- logic/xlat_check.sv
`default_nettype none
`include "xlat_settings.svh"

module xlat_check (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          front_valid,
    input  wire xlat_pkg::front_t        front,
    input  wire xlat_pkg::tlb_match_t    match,
    output logic                         rsp_valid,
    output xlat_pkg::xlat_rsp_t          rsp
);

    xlat_pkg::fault_e    tlb_fault;
    xlat_pkg::xlat_rsp_t rsp_next;

    // first matching rule wins
    always_comb
    begin
        if (!match.found)
        begin
            tlb_fault = xlat_pkg::fault_refill;
        end
        else if (!match.page.v)
        begin
            case (front.req.access)
                xlat_pkg::acc_fetch: tlb_fault = xlat_pkg::fault_inv_fetch;
                xlat_pkg::acc_load:  tlb_fault = xlat_pkg::fault_inv_load;
                default:             tlb_fault = xlat_pkg::fault_inv_store;
            endcase
        end
        else if (front.req.plv > match.page.plv)
        begin
            tlb_fault = xlat_pkg::fault_priv;
        end
        else if ((front.req.access == xlat_pkg::acc_store) && !match.page.d)
        begin
            // store to a clean page
            tlb_fault = xlat_pkg::fault_modify;
        end
        else
        begin
            tlb_fault = xlat_pkg::fault_none;
        end
    end

    always_comb
    begin
        if (!front.use_tlb)
        begin
            // direct or window result from stage 1
            rsp_next.paddr = front.paddr;
            rsp_next.mat   = front.mat;
            rsp_next.fault = xlat_pkg::fault_none;
        end
        else if (tlb_fault != xlat_pkg::fault_none)
        begin
            rsp_next.paddr = '0;
            rsp_next.mat   = 2'd0;
            rsp_next.fault = tlb_fault;
        end
        else
        begin
            rsp_next.paddr = {match.page.ppn, front.req.vaddr[`XLAT_PAGE_OFS_W-1:0]};
            rsp_next.mat   = match.page.mat;
            rsp_next.fault = xlat_pkg::fault_none;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            rsp_valid <= 1'b0;
        else
            rsp_valid <= front_valid;
    end

    always_ff @(posedge clk)
    begin
        rsp <= rsp_next;
    end

endmodule

`default_nettype wire

//--- logic/tlb_array.sv
`default_nettype none
`include "xlat_settings.svh"

module tlb_array (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              we,
    input  wire [`XLAT_TLB_IDX_W-1:0]        windex,
    input  wire xlat_pkg::tlb_entry_t        wentry,
    input  wire [`XLAT_VA_W-1:0]             vaddr,
    input  wire [`XLAT_ASID_W-1:0]           asid,
    output xlat_pkg::tlb_match_t             match
);

    xlat_pkg::tlb_entry_t          entries [`XLAT_TLB_ENTRIES];
    logic [`XLAT_TLB_ENTRIES-1:0]  hit;
    logic [`XLAT_VPPN_W-1:0]       vppn;
    logic                          odd_page;

    assign vppn     = vaddr[`XLAT_VA_W-1 -: `XLAT_VPPN_W];
    assign odd_page = vaddr[`XLAT_PAGE_OFS_W];

    // only the e bits are cleared, the rest keeps its contents
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `XLAT_TLB_ENTRIES; i++)
            begin
                entries[i].e <= 1'b0;
            end
        end
        else if (we)
        begin
            entries[windex] <= wentry;
        end
    end

    // parallel tag compare on every entry
    always_comb
    begin
        for (int i = 0; i < `XLAT_TLB_ENTRIES; i++)
        begin
            hit[i] = entries[i].e
                  && (entries[i].vppn == vppn)
                  && (entries[i].g || (entries[i].asid == asid));
        end
    end

    // lowest index wins when entries overlap
    always_comb
    begin
        logic                       found;
        logic [`XLAT_TLB_IDX_W-1:0] index;
        found = 1'b0;
        index = '0;
        for (int i = 0; i < `XLAT_TLB_ENTRIES; i++)
        begin
            if (hit[i] && !found)
            begin
                found = 1'b1;
                index = i[`XLAT_TLB_IDX_W-1:0];
            end
        end
        match.found = found;
        match.index = index;
        if (odd_page)
            match.page = entries[index].page1;
        else
            match.page = entries[index].page0;
    end

endmodule

`default_nettype wire

//--- logic/xlat_front.sv
`default_nettype none
`include "xlat_settings.svh"

module xlat_front (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        req_valid,
    input  wire xlat_pkg::xlat_req_t   req,
    input  wire xlat_pkg::xlat_cfg_t   cfg,
    output logic                       front_valid,
    output xlat_pkg::front_t           front
);

    logic             dmw0_hit;
    logic             dmw1_hit;
    xlat_pkg::front_t front_next;

    // window needs matching segment and an enabled privilege level
    function automatic logic dmw_match(
        input xlat_pkg::dmw_t      dmw,
        input xlat_pkg::xlat_req_t r
    );
        logic plv_ok;
        plv_ok = ((r.plv == 2'd0) && dmw.plv0) || ((r.plv == 2'd3) && dmw.plv3);
        return plv_ok && (r.vaddr[`XLAT_VA_W-1 -: `XLAT_SEG_W] == dmw.vseg);
    endfunction

    assign dmw0_hit = dmw_match(cfg.dmw0, req);
    assign dmw1_hit = dmw_match(cfg.dmw1, req);

    always_comb
    begin
        front_next.req     = req;
        front_next.use_tlb = 1'b0;
        if (cfg.da)
        begin
            // direct address mode, identity mapping
            front_next.paddr = req.vaddr;
            if (req.access == xlat_pkg::acc_fetch)
                front_next.mat = cfg.datf;
            else
                front_next.mat = cfg.datm;
        end
        else if (dmw0_hit)
        begin
            front_next.paddr = {cfg.dmw0.pseg, req.vaddr[`XLAT_VA_W-`XLAT_SEG_W-1:0]};
            front_next.mat   = cfg.dmw0.mat;
        end
        else if (dmw1_hit)
        begin
            front_next.paddr = {cfg.dmw1.pseg, req.vaddr[`XLAT_VA_W-`XLAT_SEG_W-1:0]};
            front_next.mat   = cfg.dmw1.mat;
        end
        else
        begin
            // page table lookup resolves this next cycle
            front_next.use_tlb = 1'b1;
            front_next.paddr   = '0;
            front_next.mat     = 2'd0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            front_valid <= 1'b0;
        else
            front_valid <= req_valid;
    end

    always_ff @(posedge clk)
    begin
        front <= front_next;
    end

endmodule

`default_nettype wire

//--- logic/xlat_pkg.sv
`default_nettype none
`include "xlat_settings.svh"

package xlat_pkg;

    typedef enum logic [1:0] {
        acc_fetch = 2'd0,
        acc_load  = 2'd1,
        acc_store = 2'd2
    } access_e;

    // priority order lives in xlat_check
    typedef enum logic [2:0] {
        fault_none      = 3'd0,
        fault_refill    = 3'd1,
        fault_inv_fetch = 3'd2,
        fault_inv_load  = 3'd3,
        fault_inv_store = 3'd4,
        fault_priv      = 3'd5,
        fault_modify    = 3'd6
    } fault_e;

    typedef struct packed {
        logic [`XLAT_VA_W-1:0] vaddr;
        access_e               access;
        logic [1:0]            plv;
    } xlat_req_t;

    typedef struct packed {
        logic [`XLAT_PPN_W-1:0] ppn;
        logic [1:0]             plv;
        logic [1:0]             mat;
        logic                   d;
        logic                   v;
    } page_t;

    // one even/odd page pair
    typedef struct packed {
        logic                    e;
        logic [`XLAT_VPPN_W-1:0] vppn;
        logic [`XLAT_ASID_W-1:0] asid;
        logic                    g;
        page_t                   page0;
        page_t                   page1;
    } tlb_entry_t;

    typedef struct packed {
        logic                   plv0;
        logic                   plv3;
        logic [1:0]             mat;
        logic [`XLAT_SEG_W-1:0] pseg;
        logic [`XLAT_SEG_W-1:0] vseg;
    } dmw_t;

    typedef struct packed {
        logic                    da;
        logic                    pg;
        logic [1:0]              datf;
        logic [1:0]              datm;
        logic [`XLAT_ASID_W-1:0] asid;
        dmw_t                    dmw0;
        dmw_t                    dmw1;
    } xlat_cfg_t;

    // paddr and mat only meaningful when use_tlb is clear
    typedef struct packed {
        xlat_req_t             req;
        logic                  use_tlb;
        logic [`XLAT_VA_W-1:0] paddr;
        logic [1:0]            mat;
    } front_t;

    typedef struct packed {
        logic                      found;
        logic [`XLAT_TLB_IDX_W-1:0] index;
        page_t                     page;
    } tlb_match_t;

    typedef struct packed {
        logic [`XLAT_VA_W-1:0] paddr;
        logic [1:0]            mat;
        fault_e                fault;
    } xlat_rsp_t;

endpackage

`default_nettype wire

//--- logic/xlat_settings.svh
`ifndef XLAT_SETTINGS_SVH
`define XLAT_SETTINGS_SVH

// address widths, virtual and physical are the same
`define XLAT_VA_W 32
`define XLAT_PAGE_OFS_W 12

// tlb geometry
`define XLAT_TLB_ENTRIES 16
`define XLAT_TLB_IDX_W 4

// page and tag fields
`define XLAT_VPPN_W 19
`define XLAT_PPN_W 20
`define XLAT_ASID_W 10

// top address bits compared by the direct-mapped windows
`define XLAT_SEG_W 3

`endif
